// File: source/cfg_pkg.sv
`default_nettype none

package cfg_pkg;

  // ======================================================================
  // Widths of the configuration slices and shadow fields
  // ======================================================================
  typedef logic [3:0]  cfg_add_t;
  typedef logic [31:0] cfg_ctl_t;
  typedef logic [52:0] cfg_sts_t;
  typedef logic [12:0] busdev_t;
  typedef logic [31:0] csr_t;
  typedef logic [19:0] io_win_t;
  typedef logic [11:0] np_win_t;
  typedef logic [43:0] pr_win_t;
  typedef logic [23:0] tcvc_t;
  typedef logic [15:0] msi_csr_t;
  typedef logic [15:0] req_id_t;
  typedef logic [12:0] size_bytes_t;

  // Slice index as sent by the hard IP with gaps at 1, 4 and C
  typedef enum cfg_add_t {
    devctl      = 4'h0,
    linkctl     = 4'h2,
    cmd         = 4'h3,
    io_base     = 4'h5,
    io_limit    = 4'h6,
    np_window   = 4'h7,
    pr_base_lo  = 4'h8,
    pr_base_hi  = 4'h9,
    pr_limit_lo = 4'hA,
    pr_limit_hi = 4'hB,
    msi         = 4'hD,
    tcvc        = 4'hE,
    busdev      = 4'hF
  } cfg_index_e;

  // PCIe size encoding is 128 << code clamped at 4096
  function automatic size_bytes_t size_from_code(input logic [2:0] code);
    if (code >= 3'd5) begin
      return size_bytes_t'(4096);
    end
    return size_bytes_t'(13'd128 << code);
  endfunction

endpackage

`default_nettype wire

// File: source/cfg_shadow_if.sv
`timescale 1ns/1ps
`default_nettype none

interface cfg_shadow_if;

  cfg_pkg::busdev_t  busdev;
  cfg_pkg::csr_t     devcsr;
  cfg_pkg::csr_t     linkcsr;
  cfg_pkg::csr_t     prmcsr;
  cfg_pkg::io_win_t  io_bas;
  cfg_pkg::io_win_t  io_lim;
  cfg_pkg::np_win_t  np_bas;
  cfg_pkg::np_win_t  np_lim;
  cfg_pkg::pr_win_t  pr_bas;
  cfg_pkg::pr_win_t  pr_lim;
  cfg_pkg::tcvc_t    tcvcmap;
  cfg_pkg::msi_csr_t msicsr;

  // Written only by the slice sampler
  modport sampler (
    output busdev, devcsr, linkcsr, prmcsr,
    output io_bas, io_lim, np_bas, np_lim, pr_bas, pr_lim,
    output tcvcmap, msicsr
  );

  // Decoder and window checker
  modport user (
    input busdev, devcsr, linkcsr, prmcsr,
    input io_bas, io_lim, np_bas, np_lim, pr_bas, pr_lim,
    input tcvcmap, msicsr
  );

endinterface

`default_nettype wire

// File: source/tl_cfg_sample.sv
`timescale 1ns/1ps
`default_nettype none

module tl_cfg_sample #(
  parameter bit hip_sv = 1'b0
) (
  input  wire                    pld_clk,
  input  wire                    rstn,
  input  wire cfg_pkg::cfg_add_t tl_cfg_add,
  input  wire cfg_pkg::cfg_ctl_t tl_cfg_ctl,
  input  wire                    tl_cfg_ctl_wr,
  input  wire cfg_pkg::cfg_sts_t tl_cfg_sts,
  input  wire                    tl_cfg_sts_wr,
  cfg_shadow_if.sampler          shadow
);

  logic ctl_wr_r;
  logic ctl_wr_rr;
  logic ctl_wr_rrr;
  logic sts_wr_r;
  logic sts_wr_rr;
  logic sts_wr_rrr;
  logic ctl_take;
  logic sts_take;

  // ======================================================================
  // Write toggle synchronizers
  // ======================================================================
  always_ff @(posedge pld_clk or negedge rstn) begin
    if (!rstn) begin
      ctl_wr_r   <= 1'b0;
      ctl_wr_rr  <= 1'b0;
      ctl_wr_rrr <= 1'b0;
      sts_wr_r   <= 1'b0;
      sts_wr_rr  <= 1'b0;
      sts_wr_rrr <= 1'b0;
    end else begin
      ctl_wr_r   <= tl_cfg_ctl_wr;
      ctl_wr_rr  <= ctl_wr_r;
      ctl_wr_rrr <= ctl_wr_rr;
      sts_wr_r   <= tl_cfg_sts_wr;
      sts_wr_rr  <= sts_wr_r;
      sts_wr_rrr <= sts_wr_rr;
    end
  end

  // Either edge of a write signal is a new slice; stable data needs no strobe
  assign ctl_take = (ctl_wr_rr != ctl_wr_rrr) || hip_sv;
  assign sts_take = (sts_wr_rr != sts_wr_rrr) || hip_sv;

  // ======================================================================
  // Shadow register capture
  // ======================================================================
  always_ff @(posedge pld_clk or negedge rstn) begin
    if (!rstn) begin
      shadow.busdev  <= '0;
      shadow.devcsr  <= '0;
      shadow.linkcsr <= '0;
      shadow.prmcsr  <= '0;
      shadow.io_bas  <= '0;
      shadow.io_lim  <= '0;
      shadow.np_bas  <= '0;
      shadow.np_lim  <= '0;
      shadow.pr_bas  <= '0;
      shadow.pr_lim  <= '0;
      shadow.tcvcmap <= '0;
      shadow.msicsr  <= '0;
    end else begin
      // Reserved bits
      shadow.devcsr[31:20] <= '0;
      shadow.prmcsr[26:25] <= '0;
      shadow.prmcsr[23:16] <= '0;

      if (sts_take) begin
        shadow.devcsr[19:16]  <= tl_cfg_sts[52:49];
        shadow.linkcsr[31:16] <= tl_cfg_sts[46:31];
        shadow.prmcsr[31:27]  <= tl_cfg_sts[29:25];
        shadow.prmcsr[24]     <= tl_cfg_sts[24];
      end

      if (ctl_take) begin
        case (cfg_pkg::cfg_index_e'(tl_cfg_add))
          cfg_pkg::devctl:      shadow.devcsr[15:0]  <= tl_cfg_ctl[31:16];
          cfg_pkg::linkctl:     shadow.linkcsr[15:0] <= tl_cfg_ctl[31:16];
          cfg_pkg::cmd:         shadow.prmcsr[15:0]  <= tl_cfg_ctl[23:8];
          cfg_pkg::io_base:     shadow.io_bas        <= tl_cfg_ctl[19:0];
          cfg_pkg::io_limit:    shadow.io_lim        <= tl_cfg_ctl[19:0];
          cfg_pkg::np_window: begin
            shadow.np_bas <= tl_cfg_ctl[23:12];
            shadow.np_lim <= tl_cfg_ctl[11:0];
          end
          cfg_pkg::pr_base_lo:  shadow.pr_bas[31:0]  <= tl_cfg_ctl;
          cfg_pkg::pr_base_hi:  shadow.pr_bas[43:32] <= tl_cfg_ctl[11:0];
          cfg_pkg::pr_limit_lo: shadow.pr_lim[31:0]  <= tl_cfg_ctl;
          cfg_pkg::pr_limit_hi: shadow.pr_lim[43:32] <= tl_cfg_ctl[11:0];
          cfg_pkg::msi:         shadow.msicsr        <= tl_cfg_ctl[15:0];
          cfg_pkg::tcvc:        shadow.tcvcmap       <= tl_cfg_ctl[23:0];
          cfg_pkg::busdev:      shadow.busdev        <= tl_cfg_ctl[12:0];
          // Unused slices 1, 4 and C
          default: ;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: source/cfg_ctrl_decode.sv
`timescale 1ns/1ps
`default_nettype none

module cfg_ctrl_decode (
  input  wire                   pld_clk,
  input  wire                   rstn,
  cfg_shadow_if.user            shadow,
  output cfg_pkg::size_bytes_t  max_payload_bytes,
  output cfg_pkg::size_bytes_t  max_read_bytes,
  output logic                  bus_master_en,
  output logic                  mem_space_en,
  output logic                  io_space_en,
  output logic                  msi_en,
  output logic [5:0]            msi_vectors,
  output cfg_pkg::req_id_t      requester_id
);

  logic [2:0] mmc_code;
  logic [5:0] vec_count;

  // Multiple message enable gives 32 vectors at most
  assign mmc_code  = shadow.msicsr[6:4];
  assign vec_count = (mmc_code >= 3'd5) ? 6'd32 : (6'd1 << mmc_code);

  always_ff @(posedge pld_clk or negedge rstn) begin
    if (!rstn) begin
      max_payload_bytes <= '0;
      max_read_bytes    <= '0;
      bus_master_en     <= 1'b0;
      mem_space_en      <= 1'b0;
      io_space_en       <= 1'b0;
      msi_en            <= 1'b0;
      msi_vectors       <= '0;
      requester_id      <= '0;
    end else begin
      // Device control sizes
      max_payload_bytes <= cfg_pkg::size_from_code(shadow.devcsr[7:5]);
      max_read_bytes    <= cfg_pkg::size_from_code(shadow.devcsr[14:12]);

      // Command register enables
      bus_master_en <= shadow.prmcsr[2];
      mem_space_en  <= shadow.prmcsr[1];
      io_space_en   <= shadow.prmcsr[0];

      msi_en      <= shadow.msicsr[0];
      msi_vectors <= vec_count;

      // Function number is always zero
      requester_id <= {shadow.busdev, 3'b000};
    end
  end

endmodule

`default_nettype wire

// File: source/cfg_window_check.sv
`timescale 1ns/1ps
`default_nettype none

module cfg_window_check (
  input  wire              pld_clk,
  input  wire              rstn,
  input  wire              req_valid,
  input  wire [63:0]       req_addr,
  input  wire              req_io,
  cfg_shadow_if.user       shadow,
  output logic             hit_valid,
  output logic             hit_io,
  output logic             hit_np,
  output logic             hit_pref
);

  cfg_pkg::io_win_t addr_io;
  cfg_pkg::np_win_t addr_np;
  cfg_pkg::pr_win_t addr_pr;
  logic             in_io;
  logic             in_np;
  logic             in_pref;

  assign addr_io = req_addr[31:12];
  assign addr_np = req_addr[31:20];
  assign addr_pr = req_addr[63:20];

  // ======================================================================
  // Window compares with inclusive limits
  // ======================================================================
  assign in_io = req_io && (addr_io >= shadow.io_bas) && (addr_io <= shadow.io_lim);

  // Non-prefetchable window lives below 4 GB only
  assign in_np = !req_io && (req_addr[63:32] == 32'h0) &&
                 (addr_np >= shadow.np_bas) && (addr_np <= shadow.np_lim);

  assign in_pref = !req_io && (addr_pr >= shadow.pr_bas) && (addr_pr <= shadow.pr_lim);

  // One result per request with flags low between results
  always_ff @(posedge pld_clk or negedge rstn) begin
    if (!rstn) begin
      hit_valid <= 1'b0;
      hit_io    <= 1'b0;
      hit_np    <= 1'b0;
      hit_pref  <= 1'b0;
    end else begin
      hit_valid <= req_valid;
      hit_io    <= req_valid && in_io;
      hit_np    <= req_valid && in_np;
      hit_pref  <= req_valid && in_pref;
    end
  end

endmodule

`default_nettype wire

// File: source/pcie_cfg_top.sv
`timescale 1ns/1ps
`default_nettype none

module pcie_cfg_top #(
  parameter bit hip_sv = 1'b0
) (
  input  wire                        pld_clk,
  input  wire                        rstn,
  input  wire cfg_pkg::cfg_add_t     tl_cfg_add,
  input  wire cfg_pkg::cfg_ctl_t     tl_cfg_ctl,
  input  wire                        tl_cfg_ctl_wr,
  input  wire cfg_pkg::cfg_sts_t     tl_cfg_sts,
  input  wire                        tl_cfg_sts_wr,
  input  wire                        req_valid,
  input  wire [63:0]                 req_addr,
  input  wire                        req_io,
  output wire cfg_pkg::busdev_t      cfg_busdev,
  output wire cfg_pkg::csr_t         cfg_devcsr,
  output wire cfg_pkg::csr_t         cfg_linkcsr,
  output wire cfg_pkg::csr_t         cfg_prmcsr,
  output wire cfg_pkg::msi_csr_t     cfg_msicsr,
  output wire cfg_pkg::tcvc_t        cfg_tcvcmap,
  output wire cfg_pkg::size_bytes_t  max_payload_bytes,
  output wire cfg_pkg::size_bytes_t  max_read_bytes,
  output wire                        bus_master_en,
  output wire                        mem_space_en,
  output wire                        io_space_en,
  output wire                        msi_en,
  output wire [5:0]                  msi_vectors,
  output wire cfg_pkg::req_id_t      requester_id,
  output wire                        hit_valid,
  output wire                        hit_io,
  output wire                        hit_np,
  output wire                        hit_pref
);

  cfg_shadow_if shadow ();

  tl_cfg_sample #(
    .hip_sv(hip_sv)
  ) u_sample (
    .pld_clk       (pld_clk),
    .rstn          (rstn),
    .tl_cfg_add    (tl_cfg_add),
    .tl_cfg_ctl    (tl_cfg_ctl),
    .tl_cfg_ctl_wr (tl_cfg_ctl_wr),
    .tl_cfg_sts    (tl_cfg_sts),
    .tl_cfg_sts_wr (tl_cfg_sts_wr),
    .shadow        (shadow.sampler)
  );

  cfg_ctrl_decode u_decode (
    .pld_clk           (pld_clk),
    .rstn              (rstn),
    .shadow            (shadow.user),
    .max_payload_bytes (max_payload_bytes),
    .max_read_bytes    (max_read_bytes),
    .bus_master_en     (bus_master_en),
    .mem_space_en      (mem_space_en),
    .io_space_en       (io_space_en),
    .msi_en            (msi_en),
    .msi_vectors       (msi_vectors),
    .requester_id      (requester_id)
  );

  cfg_window_check u_window (
    .pld_clk   (pld_clk),
    .rstn      (rstn),
    .req_valid (req_valid),
    .req_addr  (req_addr),
    .req_io    (req_io),
    .shadow    (shadow.user),
    .hit_valid (hit_valid),
    .hit_io    (hit_io),
    .hit_np    (hit_np),
    .hit_pref  (hit_pref)
  );

  // Raw shadow registers for the application
  assign cfg_busdev  = shadow.busdev;
  assign cfg_devcsr  = shadow.devcsr;
  assign cfg_linkcsr = shadow.linkcsr;
  assign cfg_prmcsr  = shadow.prmcsr;
  assign cfg_msicsr  = shadow.msicsr;
  assign cfg_tcvcmap = shadow.tcvcmap;

endmodule

`default_nettype wire

// File: verification/cfg_checker.sv
`timescale 1ns/1ps
`default_nettype none

module cfg_checker (
  input wire        pld_clk,
  input wire        rstn,
  input wire [3:0]  tl_cfg_add,
  input wire [31:0] tl_cfg_ctl,
  input wire        tl_cfg_ctl_wr,
  input wire [52:0] tl_cfg_sts,
  input wire        tl_cfg_sts_wr,
  input wire        req_valid,
  input wire [63:0] req_addr,
  input wire        req_io,
  input wire [12:0] cfg_busdev,
  input wire [31:0] cfg_devcsr,
  input wire [31:0] cfg_linkcsr,
  input wire [31:0] cfg_prmcsr,
  input wire [15:0] cfg_msicsr,
  input wire [23:0] cfg_tcvcmap,
  input wire [12:0] max_payload_bytes,
  input wire [12:0] max_read_bytes,
  input wire        bus_master_en,
  input wire        mem_space_en,
  input wire        io_space_en,
  input wire        msi_en,
  input wire [5:0]  msi_vectors,
  input wire [15:0] requester_id,
  input wire        hit_valid,
  input wire        hit_io,
  input wire        hit_np,
  input wire        hit_pref
);

  event  test_start;
  string test_name = "";
  int    checks = 0;
  int    errors = 0;
  int    test_errors = 0;
  int    tests_run = 0;

  // Model shadow
  logic [12:0] m_busdev = '0;
  logic [31:0] m_devcsr = '0;
  logic [31:0] m_linkcsr = '0;
  logic [31:0] m_prmcsr = '0;
  logic [19:0] m_io_bas = '0;
  logic [19:0] m_io_lim = '0;
  logic [11:0] m_np_bas = '0;
  logic [11:0] m_np_lim = '0;
  logic [43:0] m_pr_bas = '0;
  logic [43:0] m_pr_lim = '0;
  logic [23:0] m_tcvc = '0;
  logic [15:0] m_msi = '0;

  logic        ctl_wr_q = 1'b0;
  logic        sts_wr_q = 1'b0;
  logic        ctl_seen;
  logic        sts_seen;
  logic [3:0]  add_q;
  logic [31:0] ctl_q;
  logic [52:0] sts_q;
  logic        exp_hit_valid = 1'b0;
  logic [2:0]  exp_hits = 3'b000;

  // ======================================================================
  // Reference model
  // ======================================================================
  function automatic void apply_ctl(input logic [3:0] add, input logic [31:0] ctl);
    case (add)
      4'h0: m_devcsr[15:0] = ctl[31:16];
      4'h2: m_linkcsr[15:0] = ctl[31:16];
      4'h3: m_prmcsr[15:0] = ctl[23:8];
      4'h5: m_io_bas = ctl[19:0];
      4'h6: m_io_lim = ctl[19:0];
      4'h7: begin
        m_np_bas = ctl[23:12];
        m_np_lim = ctl[11:0];
      end
      4'h8: m_pr_bas[31:0] = ctl;
      4'h9: m_pr_bas[43:32] = ctl[11:0];
      4'hA: m_pr_lim[31:0] = ctl;
      4'hB: m_pr_lim[43:32] = ctl[11:0];
      4'hD: m_msi = ctl[15:0];
      4'hE: m_tcvc = ctl[23:0];
      4'hF: m_busdev = ctl[12:0];
      default: ;
    endcase
  endfunction

  function automatic void apply_sts(input logic [52:0] sts);
    m_devcsr[19:16] = sts[52:49];
    m_linkcsr[31:16] = sts[46:31];
    m_prmcsr[31:27] = sts[29:25];
    m_prmcsr[24] = sts[24];
  endfunction

  function automatic logic [12:0] exp_size(input logic [2:0] code);
    int bytes;
    bytes = 128 * (2 ** code);
    if (bytes > 4096) begin
      bytes = 4096;
    end
    return bytes[12:0];
  endfunction

  function automatic logic [5:0] exp_vectors(input logic [2:0] code);
    int v;
    v = 2 ** code;
    if (v > 32) begin
      v = 32;
    end
    return v[5:0];
  endfunction

  // Flags in the order io, np, pref
  function automatic logic [2:0] window_hits(input logic [63:0] addr, input logic io);
    logic h_io;
    logic h_np;
    logic h_pref;
    h_io = io && (addr[31:12] >= m_io_bas) && (addr[31:12] <= m_io_lim);
    h_np = !io && (addr[63:32] == 32'h0) &&
           (addr[31:20] >= m_np_bas) && (addr[31:20] <= m_np_lim);
    h_pref = !io && (addr[63:20] >= m_pr_bas) && (addr[63:20] <= m_pr_lim);
    return {h_io, h_np, h_pref};
  endfunction

  // ======================================================================
  // Compare and report
  // ======================================================================
  task automatic check_value(input string what, input logic [63:0] exp,
                             input logic [63:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      test_errors++;
      $display("error %s: %s expected %0h actual %0h", test_name, what, exp, act);
    end
  endtask

  task automatic compare_shadow();
    check_value("cfg_busdev", m_busdev, cfg_busdev);
    check_value("cfg_devcsr", m_devcsr, cfg_devcsr);
    check_value("cfg_linkcsr", m_linkcsr, cfg_linkcsr);
    check_value("cfg_prmcsr", m_prmcsr, cfg_prmcsr);
    check_value("cfg_msicsr", m_msi, cfg_msicsr);
    check_value("cfg_tcvcmap", m_tcvc, cfg_tcvcmap);
  endtask

  task automatic compare_decoded();
    check_value("max_payload_bytes", exp_size(m_devcsr[7:5]), max_payload_bytes);
    check_value("max_read_bytes", exp_size(m_devcsr[14:12]), max_read_bytes);
    check_value("bus_master_en", m_prmcsr[2], bus_master_en);
    check_value("mem_space_en", m_prmcsr[1], mem_space_en);
    check_value("io_space_en", m_prmcsr[0], io_space_en);
    check_value("msi_en", m_msi[0], msi_en);
    check_value("msi_vectors", exp_vectors(m_msi[6:4]), msi_vectors);
    check_value("requester_id", {m_busdev, 3'b000}, requester_id);
  endtask

  task automatic report_test();
    tests_run++;
    if (test_errors == 0) begin
      $display("test %-12s ok", test_name);
    end else begin
      $display("test %-12s %0d errors", test_name, test_errors);
    end
  endtask

  task automatic report_totals();
    if (checks == 0) begin
      errors++;
      $display("no output was ever compared");
    end
    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
  endtask

  always @(test_start) begin
    test_errors = 0;
  end

  initial begin : reset_compare
    @(posedge rstn);
    repeat (2) @(negedge pld_clk);
    compare_shadow();
    compare_decoded();
    check_value("hit io/np/pref", 3'b000, {hit_io, hit_np, hit_pref});
  end

  // Shadow is visible three cycles after the toggle and decoded controls one later
  initial begin : toggle_compare
    forever begin
      @(posedge pld_clk);
      ctl_seen = rstn && (tl_cfg_ctl_wr !== ctl_wr_q);
      sts_seen = rstn && (tl_cfg_sts_wr !== sts_wr_q);
      ctl_wr_q = tl_cfg_ctl_wr;
      sts_wr_q = tl_cfg_sts_wr;
      if (ctl_seen || sts_seen) begin
        add_q = tl_cfg_add;
        ctl_q = tl_cfg_ctl;
        sts_q = tl_cfg_sts;
        repeat (2) @(posedge pld_clk);
        @(negedge pld_clk);
        if (ctl_seen) begin
          apply_ctl(add_q, ctl_q);
        end
        if (sts_seen) begin
          apply_sts(sts_q);
        end
        compare_shadow();
        @(negedge pld_clk);
        compare_decoded();
      end
    end
  end

  always @(posedge pld_clk) begin
    exp_hit_valid <= rstn && req_valid;
    exp_hits      <= (rstn && req_valid) ? window_hits(req_addr, req_io) : 3'b000;
  end

  always @(negedge pld_clk) begin
    if (rstn) begin
      check_value("hit_valid", exp_hit_valid, hit_valid);
      if (exp_hit_valid) begin
        check_value("hit io/np/pref", exp_hits, {hit_io, hit_np, hit_pref});
      end
    end
  end

endmodule

`default_nettype wire

// File: verification/tb_pcie_cfg.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pcie_cfg;

  localparam int clk_period  = 100;
  localparam int num_tests   = 6;
  localparam int test_cycles = 400;

  logic        pld_clk;
  logic        rstn;
  logic [3:0]  tl_cfg_add;
  logic [31:0] tl_cfg_ctl;
  logic        tl_cfg_ctl_wr;
  logic [52:0] tl_cfg_sts;
  logic        tl_cfg_sts_wr;
  logic        req_valid;
  logic [63:0] req_addr;
  logic        req_io;
  wire  [12:0] cfg_busdev;
  wire  [31:0] cfg_devcsr;
  wire  [31:0] cfg_linkcsr;
  wire  [31:0] cfg_prmcsr;
  wire  [15:0] cfg_msicsr;
  wire  [23:0] cfg_tcvcmap;
  wire  [12:0] max_payload_bytes;
  wire  [12:0] max_read_bytes;
  wire         bus_master_en;
  wire         mem_space_en;
  wire         io_space_en;
  wire         msi_en;
  wire  [5:0]  msi_vectors;
  wire  [15:0] requester_id;
  wire         hit_valid;
  wire         hit_io;
  wire         hit_np;
  wire         hit_pref;

  logic [31:0] lcg_state = 32'd68162;

  pcie_cfg_top #(
    .hip_sv(1'b0)
  ) UUT (.*);

  cfg_checker chk (.*);

  initial begin : clock_gen
    pld_clk = 1'b0;
    forever begin
      #(clk_period / 2) pld_clk = ~pld_clk;
    end
  end

  initial begin : watchdog
    #(2 * num_tests * test_cycles * clk_period);
    $display("timeout: the run did not finish within %0d cycles",
             2 * num_tests * test_cycles);
    $display("Result: FAILED");
    $finish;
  end

  // ======================================================================
  // Stimulus helpers called on a falling edge
  // ======================================================================
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic start_test(input string name);
    chk.test_name = name;
    -> chk.test_start;
  endtask

  // Data stays put for six cycles after the toggle
  task automatic write_ctl(input logic [3:0] add, input logic [31:0] data);
    tl_cfg_add    = add;
    tl_cfg_ctl    = data;
    tl_cfg_ctl_wr = ~tl_cfg_ctl_wr;
    repeat (6) @(negedge pld_clk);
  endtask

  task automatic write_sts();
    logic [63:0] wide;
    wide          = {next_rand(), next_rand()};
    tl_cfg_sts    = wide[52:0];
    tl_cfg_sts_wr = ~tl_cfg_sts_wr;
    repeat (6) @(negedge pld_clk);
  endtask

  task automatic run_ctl_writes();
    logic [31:0] r;
    for (int i = 0; i < 40; i++) begin
      r = next_rand();
      write_ctl((i < 32) ? 4'(i) : r[3:0], next_rand());
    end
  endtask

  // Every size, enable and vector code in turn
  task automatic run_decode_sweep();
    logic [31:0] r;
    for (int code = 0; code < 8; code++) begin
      r = next_rand();
      r[23:21] = 3'(code);
      r[30:28] = 3'(7 - code);
      write_ctl(4'h0, r);
      r = next_rand();
      r[10:8] = 3'(code);
      write_ctl(4'h3, r);
      r = next_rand();
      r[6:4] = 3'(code);
      write_ctl(4'hD, r);
      write_ctl(4'hF, next_rand());
    end
  endtask

  task automatic run_windows();
    logic [31:0] r;
    logic [19:0] io_b;
    logic [19:0] io_l;
    logic [11:0] np_b;
    logic [11:0] np_l;
    logic [43:0] pr_b;
    logic [43:0] pr_l;
    r    = next_rand();
    io_b = {1'b0, r[18:0]};
    io_l = io_b + r[26:19];
    np_b = {1'b0, r[10:0]};
    np_l = np_b + r[30:27];
    pr_b = {1'b0, r[10:0], next_rand()};
    pr_l = pr_b + next_rand() % 65536;
    write_ctl(4'h5, {12'h0, io_b});
    write_ctl(4'h6, {12'h0, io_l});
    write_ctl(4'h7, {8'h0, np_b, np_l});
    write_ctl(4'h8, pr_b[31:0]);
    write_ctl(4'h9, {20'h0, pr_b[43:32]});
    write_ctl(4'hA, pr_l[31:0]);
    write_ctl(4'hB, {20'h0, pr_l[43:32]});
    // Base minus one and limit plus one straddle each edge
    for (int i = 0; i < 80; i++) begin
      r         = next_rand();
      req_valid = 1'b1;
      req_io    = 1'b0;
      case (r[7:4] % 7)
        0: req_addr = {32'h0, io_b - r[0], r[19:8]};
        1: req_addr = {32'h0, io_l + r[0], r[19:8]};
        2: req_addr = {32'h0, np_b - r[0], r[27:8]};
        3: req_addr = {32'h0, np_l + r[0], r[27:8]};
        4: req_addr = {pr_b - r[0], r[27:8]};
        5: req_addr = {pr_l + r[0], r[27:8]};
        default: req_addr = {(r[2] ? next_rand() : 32'h0), next_rand()};
      endcase
      req_io = (r[7:4] % 7 < 2) ? 1'b1 : (r[3:1] == 3'd0);
      @(negedge pld_clk);
      if (r[31:30] == 2'b00) begin
        req_valid = 1'b0;
        @(negedge pld_clk);
      end
    end
    req_valid = 1'b0;
    repeat (3) @(negedge pld_clk);
  endtask

  // ======================================================================
  // Test sequence
  // ======================================================================
  initial begin : stimulus
    rstn          = 1'b0;
    tl_cfg_add    = '0;
    tl_cfg_ctl    = '0;
    tl_cfg_ctl_wr = 1'b0;
    tl_cfg_sts    = '0;
    tl_cfg_sts_wr = 1'b0;
    req_valid     = 1'b0;
    req_addr      = '0;
    req_io        = 1'b0;
    #1;
    start_test("reset");
    repeat (4) @(negedge pld_clk);
    rstn = 1'b1;
    repeat (3) @(negedge pld_clk);
    chk.report_test();

    start_test("ctl_writes");
    run_ctl_writes();
    chk.report_test();

    start_test("sts_writes");
    repeat (12) write_sts();
    chk.report_test();

    start_test("decode");
    run_decode_sweep();
    chk.report_test();

    start_test("windows");
    run_windows();
    chk.report_test();

    // Each pass flips both write signals so rising and falling alternate
    start_test("toggle_dirs");
    repeat (6) begin
      write_ctl(4'(next_rand()), next_rand());
      write_sts();
    end
    chk.report_test();

    chk.report_totals();
    if (chk.errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
source/cfg_pkg.sv
source/cfg_shadow_if.sv
source/tl_cfg_sample.sv
source/cfg_ctrl_decode.sv
source/cfg_window_check.sv
source/pcie_cfg_top.sv
verification/cfg_checker.sv
verification/tb_pcie_cfg.sv

// File: Bender.yml
package:
  name: pcie_cfg

sources:
  - source/cfg_pkg.sv
  - source/cfg_shadow_if.sv
  - source/tl_cfg_sample.sv
  - source/cfg_ctrl_decode.sv
  - source/cfg_window_check.sv
  - source/pcie_cfg_top.sv
  - target: test
    files:
      - verification/cfg_checker.sv
      - verification/tb_pcie_cfg.sv
